// File: compile.f
+incdir+source
+incdir+tb
source/strided_copy_pkg.sv
source/stride_addr_gen.sv
source/addr_pair_joiner.sv
source/copy_job_launcher.sv
source/strided_copy_top.sv
tb/tb_strided_copy.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the strided copy testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing -f compile.f --top-module tb_strided_copy \
  --Mdir obj_dir -o sim_strided_copy > build.log 2>&1 \
  && ./obj_dir/sim_strided_copy > sim.log 2>&1 \
  || echo "build or simulation ended with an error, see build.log and sim.log"

touch sim.log
cat sim.log

grep -q "^TEST PASS$" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

exit 0

// File: tb/copy_ref_model.svh
// copy address reference model
`ifndef COPY_REF_MODEL_SVH
`define COPY_REF_MODEL_SVH

  // split k into i2, i1, i0, then base + i2*s2 + i1*s1 + i0*s0
  function automatic addr_t ref_addr(input walk_cfg_t cfg, input int unsigned k);
    int unsigned d0;
    int unsigned d1;
    int unsigned i0;
    int unsigned i1;
    int unsigned i2;
    addr_t       a;
    d0 = 32'(cfg.d0_len);
    d1 = 32'(cfg.d1_len);
    if (!cfg.dim_en[0]) begin
      i0 = k;                // 1-D, i0 never wraps
      i1 = 0;
      i2 = 0;
    end else if (!cfg.dim_en[1]) begin
      i0 = k % d0;           // 2-D, i1 never wraps
      i1 = k / d0;
      i2 = 0;
    end else begin
      i0 = k % d0;
      i1 = (k / d0) % d1;
      i2 = k / (d0 * d1);
    end
    a = cfg.base;
    a = a + addr_t'(i0) * addr_t'(cfg.d0_stride);  // products wrap like the address
    a = a + addr_t'(i1) * addr_t'(cfg.d1_stride);
    a = a + addr_t'(i2) * addr_t'(cfg.d2_stride);
    return a;
  endfunction

  // k-th pair, source and destination walk the same index
  function automatic copy_req_t ref_req(input walk_cfg_t src, input walk_cfg_t dst,
                                        input int unsigned k);
    copy_req_t r;
    r.src_addr = ref_addr(src, k);
    r.dst_addr = ref_addr(dst, k);
    return r;
  endfunction

  // 16-bit Galois LFSR, taps x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hb400;  // feedback from the bit shifted out
    end
    return n;
  endfunction

`endif

// File: tb/tb_strided_copy.sv
// strided copy testbench
`timescale 1ns/10ps
`default_nettype none

module tb_strided_copy
  import strided_copy_pkg::*;
();

  localparam int NJOBS = 5;

  logic      clk = 1'b0;
  logic      rst_n, start, req_ready;
  walk_cfg_t src_cfg, dst_cfg;
  copy_req_t copy_req;
  logic      req_valid, busy, done;

  walk_cfg_t   src_tab [NJOBS];  // job table
  walk_cfg_t   dst_tab [NJOBS];
  int unsigned pct_tab [NJOBS];  // req_ready high chance in percent

  logic [15:0] lfsr_q = 16'd95;
  int          req_errs = 0;
  int          count_errs = 0;
  int          ctrl_errs = 0;
  int unsigned wd_cycles = 0;
  logic        tab_ready = 1'b0;

  `include "copy_ref_model.svh"

  strided_copy_top i_dut (
    .clk_i(clk), .rst_ni(rst_n), .start_i(start),
    .src_cfg_i(src_cfg), .dst_cfg_i(dst_cfg),
    .copy_req_o(copy_req), .req_valid_o(req_valid), .req_ready_i(req_ready),
    .busy_o(busy), .done_o(done)
  );

  always #5 clk = ~clk;  // 10 ns period

  function automatic walk_cfg_t make_cfg(input addr_t base, input int tot, input int d0,
                                         input int d1, input int s0, input int s1,
                                         input int s2, input dim_en_t dim);
    walk_cfg_t c;
    c.base      = base;
    c.tot_len   = len_t'(tot);
    c.d0_len    = len_t'(d0);
    c.d1_len    = len_t'(d1);
    c.d0_stride = stride_t'(s0);
    c.d1_stride = stride_t'(s1);
    c.d2_stride = stride_t'(s2);
    c.dim_en    = dim;
    return c;
  endfunction

  task automatic check_req(input copy_req_t got, input copy_req_t exp, input int unsigned k);
    if (got !== exp) begin
      req_errs++;
      $display("Fail %0t: request %0d src %h dst %h, expected src %h dst %h", $time, k,
               got.src_addr, got.dst_addr, exp.src_addr, exp.dst_addr);
    end
  endtask

  task automatic check_count(input len_t got, input len_t exp);
    if (got !== exp) begin
      count_errs++;
      $display("Fail %0t: %0d requests accepted, expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      ctrl_errs++;
      $display("Fail %0t: %s, got %b", $time, what, got);
    end
  endtask

  // 7 LFSR bits per cycle give a ready draw
  task automatic draw_ready(input int unsigned pct, output logic rdy);
    logic [6:0] v;
    v = '0;
    if (pct >= 100) begin
      rdy = 1'b1;
    end else begin
      for (int b = 0; b < 7; b++) begin
        v = {v[5:0], lfsr_q[0]};  // one step per bit
        lfsr_q = lfsr_next(lfsr_q);
      end
      rdy = (int'(v) * 100 < int'(pct) * 128);
    end
  endtask

  task automatic run_job(input int j);
    int unsigned nreq;
    int unsigned ncyc;
    logic        rdy;
    logic        ended;
    copy_req_t   exp;
    nreq  = 0;
    ncyc  = 0;
    ended = 1'b0;
    @(posedge clk);
    src_cfg <= src_tab[j];
    dst_cfg <= dst_tab[j];
    start   <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
    while (!ended) begin
      @(negedge clk);  // outputs settled here
      if (req_valid && req_ready) begin
        exp = ref_req(src_tab[j], dst_tab[j], nreq);
        check_req(copy_req, exp, nreq);
        nreq++;
      end
      if (done) begin
        ended = 1'b1;
        check_flag(busy, 1'b0, "busy still high at done");
        check_count(len_t'(nreq), src_tab[j].tot_len);
      end else begin
        check_flag(busy, 1'b1, "busy low during job");
      end
      ncyc++;
      @(posedge clk);
      draw_ready(pct_tab[j], rdy);
      req_ready <= rdy;
      start     <= (ncyc == 6);  // stray start while busy
    end
    repeat (8) begin
      @(negedge clk);
      check_flag(busy, 1'b0, "busy after job end");
      check_flag(done, 1'b0, "extra done pulse");
      check_flag(req_valid, 1'b0, "request after job end");
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    start     = 1'b0;
    req_ready = 1'b0;
    src_cfg   = '0;
    dst_cfg   = '0;
    // 1-D positive strides running past d0_len
    src_tab[0] = make_cfg(32'h0000_1000, 12, 5, 1, 4, 0, 0, 2'b00);
    dst_tab[0] = make_cfg(32'h0000_8000, 12, 7, 1, 8, 0, 0, 2'b00);
    pct_tab[0] = 100;
    // 2-D negative d1 stride with i1 past d1_len
    src_tab[1] = make_cfg(32'h0000_2000, 12, 4, 2, 4, -64, 0, 2'b01);
    dst_tab[1] = make_cfg(32'h0000_9000, 12, 6, 1, 4, -32, 0, 2'b01);
    pct_tab[1] = 70;
    // 3-D with different shapes
    src_tab[2] = make_cfg(32'h0000_4000, 24, 2, 3, 4, 16, 256, 2'b11);
    dst_tab[2] = make_cfg(32'h0000_a000, 24, 4, 2, 8, -128, 1024, 2'b11);
    pct_tab[2] = 50;
    // heavy back-pressure
    src_tab[3] = make_cfg(32'h0001_0000, 40, 5, 4, 4, 32, -512, 2'b11);
    dst_tab[3] = make_cfg(32'h0002_0000, 40, 8, 5, -4, 64, 0, 2'b01);
    pct_tab[3] = 25;
    // 1-D source against 2-D destination
    src_tab[4] = make_cfg(32'h0000_0040, 16, 3, 1, 4, 0, 0, 2'b00);
    dst_tab[4] = make_cfg(32'h0000_0080, 16, 4, 4, 4, 16, 0, 2'b01);
    pct_tab[4] = 100;
    for (int j = 0; j < NJOBS; j++) begin
      wd_cycles += 200 + 4 * int'(src_tab[j].tot_len);
    end
    tab_ready = 1'b1;
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    for (int j = 0; j < NJOBS; j++) begin
      run_job(j);  // back to back jobs restart at index 0
    end
    $display("errors: request %0d, count %0d, control %0d", req_errs, count_errs, ctrl_errs);
    if (req_errs + count_errs + ctrl_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // watchdog
  initial begin
    wait (tab_ready);
    repeat (wd_cycles + 16) @(posedge clk);
    $display("timeout: the jobs did not finish within %0d cycles", wd_cycles);
    $display("TEST FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: source/strided_copy_top.sv
// strided copy address engine top
`timescale 1ns/10ps
`default_nettype none

module strided_copy_top
  import strided_copy_pkg::*;
(
  input  logic      clk_i,        // core clock
  input  logic      rst_ni,       // async reset, active low
  input  logic      start_i,      // job start pulse
  input  walk_cfg_t src_cfg_i,    // source tensor walk
  input  walk_cfg_t dst_cfg_i,    // destination tensor walk, same tot_len
  output copy_req_t copy_req_o,   // paired addresses
  output logic      req_valid_o,
  input  logic      req_ready_i,
  output logic      busy_o,       // job in flight
  output logic      done_o        // end of job pulse
);

  logic  gen_clear, gen_presample, gen_enable;  // shared walker controls
  addr_t src_addr, dst_addr;
  logic  src_valid, dst_valid;
  logic  src_ready, dst_ready;
  logic  src_done, dst_done;
  logic  join_empty;

  copy_job_launcher i_launcher (
    .clk_i, .rst_ni, .start_i,
    .src_done_i(src_done), .dst_done_i(dst_done), .join_empty_i(join_empty),
    .clear_o(gen_clear), .presample_o(gen_presample), .enable_o(gen_enable),
    .busy_o, .done_o
  );

  stride_addr_gen i_src_gen (
    .clk_i, .rst_ni,
    .clear_i(gen_clear), .presample_i(gen_presample), .enable_i(gen_enable),
    .cfg_i(src_cfg_i), .addr_o(src_addr), .addr_valid_o(src_valid),
    .addr_ready_i(src_ready), .done_o(src_done)
  );

  stride_addr_gen i_dst_gen (
    .clk_i, .rst_ni,
    .clear_i(gen_clear), .presample_i(gen_presample), .enable_i(gen_enable),
    .cfg_i(dst_cfg_i), .addr_o(dst_addr), .addr_valid_o(dst_valid),
    .addr_ready_i(dst_ready), .done_o(dst_done)
  );

  addr_pair_joiner i_joiner (
    .clk_i, .rst_ni,
    .src_addr_i(src_addr), .dst_addr_i(dst_addr),
    .src_valid_i(src_valid), .dst_valid_i(dst_valid),
    .src_ready_o(src_ready), .dst_ready_o(dst_ready),
    .req_o(copy_req_o), .req_valid_o, .req_ready_i, .empty_o(join_empty)
  );

endmodule

`default_nettype wire

// File: source/copy_job_launcher.sv
// copy job launcher
`timescale 1ns/10ps
`default_nettype none

`include "copy_settings.svh"

module copy_job_launcher
  import strided_copy_pkg::*;
(
  input  logic clk_i,         // core clock
  input  logic rst_ni,        // async reset, active low
  input  logic start_i,       // job start pulse
  input  logic src_done_i,    // source walker finished
  input  logic dst_done_i,    // destination walker finished
  input  logic join_empty_i,  // joiner holds no request
  output logic clear_o,       // walker clear
  output logic presample_o,   // walker presample
  output logic enable_o,      // walker enable
  output logic busy_o,        // job in flight
  output logic done_o         // one-cycle end of job
);

  localparam int unsigned CLR_W = $clog2(`CLR_CYC + 1);

  launch_state_e    state_q, state_d;
  logic [CLR_W-1:0] clr_cnt_q;  // cycles spent in clear
  logic             clr_last;
  logic             done_q;

  assign clr_last = (clr_cnt_q == CLR_W'(`CLR_CYC - 1));

  // next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (start_i) state_d = CLEAR;  // start while busy never reaches here
      end
      CLEAR: begin
        if (clr_last) state_d = PRESAMPLE;
      end
      PRESAMPLE: begin
        state_d = RUN;  // single cycle
      end
      RUN: begin
        if (src_done_i && dst_done_i) state_d = DRAIN;
      end
      DRAIN: begin
        if (join_empty_i) state_d = IDLE;  // last request accepted
      end
      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q   <= IDLE;
      clr_cnt_q <= '0;
      done_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      done_q  <= (state_q == DRAIN) & join_empty_i;  // pulse on drain exit
      if (state_q == CLEAR) begin
        clr_cnt_q <= clr_cnt_q + CLR_W'(1);
      end else begin
        clr_cnt_q <= '0;
      end
    end
  end

  // state decodes
  assign clear_o     = (state_q == CLEAR);
  assign presample_o = (state_q == PRESAMPLE);
  assign enable_o    = (state_q == PRESAMPLE) | (state_q == RUN);  // presample needs enable
  assign busy_o      = (state_q != IDLE);
  assign done_o      = done_q;

endmodule

`default_nettype wire

// File: source/addr_pair_joiner.sv
// address pair joiner
`timescale 1ns/10ps
`default_nettype none

module addr_pair_joiner
  import strided_copy_pkg::*;
(
  input  logic      clk_i,        // core clock
  input  logic      rst_ni,       // async reset, active low
  input  addr_t     src_addr_i,   // source walker address
  input  addr_t     dst_addr_i,   // destination walker address
  input  logic      src_valid_i,
  input  logic      dst_valid_i,
  output logic      src_ready_o,  // granted together with dst
  output logic      dst_ready_o,
  output copy_req_t req_o,        // registered request
  output logic      req_valid_o,
  input  logic      req_ready_i,  // downstream ready
  output logic      empty_o       // no request held
);

  copy_req_t req_q;
  logic      req_valid_q;

  logic      both_valid;  // a full pair is waiting
  logic      slot_free;   // register empty or being taken
  logic      accept;      // pair loads on this edge
  logic      take;        // request leaves on this edge

  assign both_valid = src_valid_i & dst_valid_i;
  assign take       = req_valid_q & req_ready_i;
  assign slot_free  = ~req_valid_q | req_ready_i;
  assign accept     = both_valid & slot_free;

  // lockstep grant, neither stream runs ahead
  assign src_ready_o = accept;
  assign dst_ready_o = accept;

  // output valid
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else if (accept) begin
      req_valid_q <= 1'b1;  // refill, also when taken this edge
    end else if (take) begin
      req_valid_q <= 1'b0;
    end
  end

  // request payload
  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_q.src_addr <= src_addr_i;
      req_q.dst_addr <= dst_addr_i;
    end
  end

  assign req_o       = req_q;
  assign req_valid_o = req_valid_q;
  assign empty_o     = ~req_valid_q;  // launcher waits on this in drain

endmodule

`default_nettype wire

// File: source/stride_addr_gen.sv
// 3-D strided address generator
`timescale 1ns/10ps
`default_nettype none

module stride_addr_gen
  import strided_copy_pkg::*;
(
  input  logic      clk_i,         // core clock
  input  logic      rst_ni,        // async reset, active low
  input  logic      clear_i,       // sync clear of walk state
  input  logic      presample_i,   // load index 0
  input  logic      enable_i,      // advance enable, freezes when low
  input  walk_cfg_t cfg_i,         // shape, strides, base
  output addr_t     addr_o,        // registered address
  output logic      addr_valid_o,  // registered valid
  input  logic      addr_ready_i,  // consumer ready
  output logic      done_o         // tot_len addresses sent
);

  // per-dimension byte offsets
  addr_t d0_off_q, d0_off_d;
  addr_t d1_off_q, d1_off_d;
  addr_t d2_off_q, d2_off_d;

  // index counters, i2 is implicit in d2_off
  len_t  i0_q, i0_d;
  len_t  i1_q, i1_d;
  len_t  ov_cnt_q, ov_cnt_d;  // transfers done so far

  addr_t addr_q, addr_d;
  logic  valid_q, valid_d;
  logic  done_q, done_d;

  logic  xfer;       // handshake on this edge
  logic  d0_wrap;    // i0 at its last value with d1 enabled
  logic  d1_wrap;    // i1 at its last value with d2 enabled
  logic  last_xfer;  // this transfer is number tot_len

  assign xfer      = valid_q & addr_ready_i;
  assign d0_wrap   = cfg_i.dim_en[0] & (i0_q == cfg_i.d0_len - len_t'(1));
  assign d1_wrap   = cfg_i.dim_en[1] & (i1_q == cfg_i.d1_len - len_t'(1));
  assign last_xfer = (ov_cnt_q == cfg_i.tot_len - len_t'(1));

  // next walk state
  always_comb begin
    d0_off_d = d0_off_q;
    d1_off_d = d1_off_q;
    d2_off_d = d2_off_q;
    i0_d     = i0_q;
    i1_d     = i1_q;
    ov_cnt_d = ov_cnt_q;
    valid_d  = valid_q;
    done_d   = done_q;
    if (presample_i) begin
      d0_off_d = '0;                             // restart at index 0
      d1_off_d = '0;
      d2_off_d = '0;
      i0_d     = '0;
      i1_d     = '0;
      ov_cnt_d = '0;
      valid_d  = (cfg_i.tot_len != '0);          // empty job emits nothing
      done_d   = (cfg_i.tot_len == '0);
    end else if (xfer) begin
      ov_cnt_d = ov_cnt_q + len_t'(1);
      if (!d0_wrap) begin
        i0_d     = i0_q + len_t'(1);             // plain inner step
        d0_off_d = d0_off_q + addr_t'(cfg_i.d0_stride);
      end else if (!d1_wrap) begin
        i0_d     = '0;                           // wrap into d1
        d0_off_d = '0;
        i1_d     = i1_q + len_t'(1);
        d1_off_d = d1_off_q + addr_t'(cfg_i.d1_stride);
      end else begin
        i0_d     = '0;                           // wrap into d2
        d0_off_d = '0;
        i1_d     = '0;
        d1_off_d = '0;
        d2_off_d = d2_off_q + addr_t'(cfg_i.d2_stride);
      end
      if (last_xfer) begin
        valid_d = 1'b0;                          // stream finished
        done_d  = 1'b1;
      end
    end
  end

  // signed strides wrap modulo 2^ADDR_W
  assign addr_d = cfg_i.base + d2_off_d + d1_off_d + d0_off_d;

  // control and counters
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      d0_off_q <= '0;
      d1_off_q <= '0;
      d2_off_q <= '0;
      i0_q     <= '0;
      i1_q     <= '0;
      ov_cnt_q <= '0;
      valid_q  <= 1'b0;
      done_q   <= 1'b0;
    end else if (clear_i) begin
      d0_off_q <= '0;
      d1_off_q <= '0;
      d2_off_q <= '0;
      i0_q     <= '0;
      i1_q     <= '0;
      ov_cnt_q <= '0;
      valid_q  <= 1'b0;
      done_q   <= 1'b0;
    end else if (enable_i) begin
      d0_off_q <= d0_off_d;
      d1_off_q <= d1_off_d;
      d2_off_q <= d2_off_d;
      i0_q     <= i0_d;
      i1_q     <= i1_d;
      ov_cnt_q <= ov_cnt_d;
      valid_q  <= valid_d;
      done_q   <= done_d;
    end
  end

  // address payload, only moves on load or transfer
  always_ff @(posedge clk_i) begin
    if (enable_i && (presample_i || xfer)) begin
      addr_q <= addr_d;
    end
  end

  assign addr_o       = addr_q;
  assign addr_valid_o = valid_q;
  assign done_o       = done_q;

endmodule

`default_nettype wire

// File: source/strided_copy_pkg.sv
// strided copy types
`default_nettype none

`include "copy_settings.svh"

package strided_copy_pkg;

  // plain vector types
  typedef logic        [`ADDR_W-1:0] addr_t;    // unsigned byte address
  typedef logic signed [`ADDR_W-1:0] stride_t;  // signed byte stride
  typedef logic        [`LEN_W-1:0]  len_t;     // transaction count
  typedef logic        [1:0]         dim_en_t;  // 00 1-D, 01 2-D, 11 3-D

  // one tensor walk
  typedef struct packed {
    addr_t   base;       // start address
    len_t    tot_len;    // addresses emitted in total
    len_t    d0_len;     // inner dimension length
    len_t    d1_len;     // middle dimension length
    stride_t d0_stride;  // step along i0
    stride_t d1_stride;  // step along i1
    stride_t d2_stride;  // step along i2
    dim_en_t dim_en;     // wrap enables for d1/d2
  } walk_cfg_t;

  // one copy request, source paired with destination
  typedef struct packed {
    addr_t src_addr;  // read side
    addr_t dst_addr;  // write side
  } copy_req_t;

  // job launcher states
  typedef enum logic [2:0] {
    IDLE,       // waiting for start
    CLEAR,      // walkers held in clear
    PRESAMPLE,  // first address loaded
    RUN,        // walkers streaming
    DRAIN       // last request leaving joiner
  } launch_state_e;

endpackage

`default_nettype wire

// File: source/copy_settings.svh
// copy engine width settings
`ifndef COPY_SETTINGS_SVH
`define COPY_SETTINGS_SVH

// byte address width, one full word per address
`define ADDR_W 32

// length and transaction counter width
// tot_len, d0_len and d1_len all share it
`define LEN_W 16

// cycles the launcher holds clear high before presample
`define CLR_CYC 2

// note: both walkers of one job need equal tot_len,
// the pair joiner pops them in lockstep

`endif
